// File: design/fm_reg_pkg.sv
// ******************************
// register map and global config types of the FM front end
// register numbers are 8 bit, part bit travels apart from them
// ******************************
package fm_reg_pkg;

	// global registers, part independent
	localparam logic [7:0] REG_TEST     = 8'h21; // stop bits, fast timers
	localparam logic [7:0] REG_LFO      = 8'h22;
	localparam logic [7:0] REG_CLKA_HI  = 8'h24; // value_a[9:2]
	localparam logic [7:0] REG_CLKA_LO  = 8'h25; // value_a[1:0]
	localparam logic [7:0] REG_CLKB     = 8'h26;
	localparam logic [7:0] REG_TIMER    = 8'h27;
	localparam logic [7:0] REG_KON      = 8'h28;
	localparam logic [7:0] REG_PCM      = 8'h2A; // pcm[8:1]
	localparam logic [7:0] REG_PCM_EN   = 8'h2B;
	localparam logic [7:0] REG_DACTEST  = 8'h2C; // pcm[0] in bit 3
	localparam logic [7:0] REG_CLK_N6   = 8'h2D;
	localparam logic [7:0] REG_CLK_N3   = 8'h2E;
	localparam logic [7:0] REG_CLK_N2   = 8'h2F;
	// voice register window, also the busy threshold
	localparam logic [7:0] REG_OP_FIRST = 8'h30;
	localparam logic [7:0] REG_OP_LAST  = 8'h9F;
	// ch3 special frequency, low byte
	localparam logic [7:0] REG_C3_OP3   = 8'hA8;
	localparam logic [7:0] REG_C3_OP1   = 8'hA9;
	localparam logic [7:0] REG_C3_OP2   = 8'hAA;
	// writes that load the shared block/fnum-high latch
	localparam logic [7:0] REG_FHI_CH1  = 8'hA4;
	localparam logic [7:0] REG_FHI_CH2  = 8'hA5;
	localparam logic [7:0] REG_FHI_CH3  = 8'hA6;
	localparam logic [7:0] REG_FHI_OP3  = 8'hAC;
	localparam logic [7:0] REG_FHI_OP1  = 8'hAD;
	localparam logic [7:0] REG_FHI_OP2  = 8'hAE;

	typedef struct packed {
		logic [7:0] reg_num; // selected register
		logic       part;    // addr[1] at select time
		logic [7:0] data;
		logic [5:0] latch;   // {block, fnum[10:8]}
	} reg_wr_t;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       irq_en_a;
		logic       irq_en_b;
		logic       clr_flag_a; // one-shot, cleared on clk_en
		logic       clr_flag_b;
		logic       fast_timers;
		logic       csm;
	} timer_cfg_t;

	typedef struct packed {
		logic [2:0] lfo_freq;
		logic       lfo_en;
		logic [8:0] pcm;
		logic       pcm_en;
		logic       eg_stop;
		logic       pg_stop;
		logic       effect; // ch3 independent frequencies
	} glob_cfg_t;

	typedef struct packed {
		logic [2:0]  block_op1;
		logic [10:0] fnum_op1;
		logic [2:0]  block_op2;
		logic [10:0] fnum_op2;
		logic [2:0]  block_op3;
		logic [10:0] fnum_op3;
	} ch3_freq_t;

endpackage

// File: design/fm_voice_pkg.sv
// ******************************
// channel, operator and slot parameter types
// op code follows register bits 3:2 (0=S1 1=S3 2=S2 3=S4)
// ******************************
package fm_voice_pkg;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;    // feedback
		logic [2:0]  alg;
		logic [1:0]  rl;    // output enables
		logic [1:0]  ams;
		logic [2:0]  pms;
	} ch_params_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amen;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] sl;
		logic [3:0] rr;
		logic [3:0] ssg; // ssg-eg enable plus mode
	} op_params_t;

	typedef struct packed {
		logic [4:0]  slot; // op * NUM_CH + ch
		logic [2:0]  ch;   // 0..5, part 1 starts at 3
		logic [1:0]  op;   // register order code
		logic        keyon;
		ch_params_t  chp;
		op_params_t  opp;
		logic        eg_stop;
		logic        pg_stop;
	} slot_t;

endpackage

// File: design/fm_param_ram.sv
// ******************************
// flop array, one write port, two async read ports
// no reset, contents undefined until written
// ******************************
`timescale 1ns/10ps

module fm_param_ram #(
	parameter type PAYLOAD = logic [7:0],
	parameter int  DEPTH   = 4
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  PAYLOAD                   wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr_a,
	output PAYLOAD                   rdata_a,
	input  logic [$clog2(DEPTH)-1:0] raddr_b,
	output PAYLOAD                   rdata_b
);

	PAYLOAD mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata_a = mem[raddr_a]; // slot side
	assign rdata_b = mem[raddr_b]; // rmw side, old value of the target

endmodule

// File: design/fm_bus_port.sv
// ******************************
// host byte bus, rising edge of write is one access
// no handshake, busy is advisory only
// ******************************
`timescale 1ns/10ps

module fm_bus_port #(
	parameter int BUSY_CLKEN = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           din,
	input  logic                 write,
	input  logic [1:0]           addr,
	input  logic                 clk_en,
	output logic                 wr_valid,
	output fm_reg_pkg::reg_wr_t  wr,
	output logic                 busy
);

	localparam int BCW = $clog2(BUSY_CLKEN) + 1;

	logic           old_write;
	logic [7:0]     sel_reg;
	logic           sel_part;
	logic [5:0]     latch;     // one latch shared by all channels
	logic [BCW-1:0] busy_cnt;
	logic           accept;
	logic           data_wr;

	assign accept  = write & ~old_write;
	assign data_wr = accept & addr[0]; // A0 high -> data

	always_ff @(posedge clk) begin
		if (rst) begin
			old_write <= 1'b1; // level held across reset is no edge
			sel_reg   <= 8'h00;
			sel_part  <= 1'b0;
			latch     <= 6'd0;
			wr_valid  <= 1'b0;
		end else begin
			old_write <= write;
			wr_valid  <= data_wr; // one-cycle strobe
			if (accept && !addr[0]) begin
				sel_reg  <= din;
				sel_part <= addr[1];
			end
			if (data_wr && sel_reg inside {fm_reg_pkg::REG_FHI_CH1, fm_reg_pkg::REG_FHI_CH2,
					fm_reg_pkg::REG_FHI_CH3, fm_reg_pkg::REG_FHI_OP1,
					fm_reg_pkg::REG_FHI_OP2, fm_reg_pkg::REG_FHI_OP3})
				latch <= din[5:0];
		end
	end

	// payload follows the strobe, carries latch as it was before this write
	always_ff @(posedge clk) begin
		if (data_wr) begin
			wr.reg_num <= sel_reg;
			wr.part    <= sel_part;
			wr.data    <= din;
			wr.latch   <= latch;
		end
	end

	// busy window, restarted by every voice data write
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (data_wr && sel_reg >= fm_reg_pkg::REG_OP_FIRST) begin
			busy     <= 1'b1;
			busy_cnt <= '0;
		end else if (busy && clk_en) begin
			if (busy_cnt == BCW'(BUSY_CLKEN - 1))
				busy <= 1'b0; // last pulse of the window
			busy_cnt <= busy_cnt + 1'b1;
		end
	end

endmodule

// File: design/fm_global_regs.sv
// ******************************
// global registers and clk_en divider (6, 3 or 2 clk)
// timers are only configured here, they do not count
// ******************************
`timescale 1ns/10ps

module fm_global_regs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wr_valid,
	input  fm_reg_pkg::reg_wr_t     wr,
	output logic                    clk_en,
	output fm_reg_pkg::timer_cfg_t  timer,
	output fm_reg_pkg::glob_cfg_t   glob,
	output fm_reg_pkg::ch3_freq_t   ch3
);

	logic [2:0] div_cnt;
	logic [2:0] div_lim; // period minus one
	logic       div_hit;

	assign div_hit = div_cnt >= div_lim; // >= so a shorter limit never overshoots

	// divider runs free, a new limit takes effect without restart
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= 3'd0;
			clk_en  <= 1'b0;
		end else begin
			clk_en  <= div_hit;
			div_cnt <= div_hit ? 3'd0 : div_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			div_lim <= 3'd5;
			timer   <= '0;
			glob    <= '0;
		end else if (wr_valid) begin
			case (wr.reg_num)
				fm_reg_pkg::REG_TEST: begin
					glob.eg_stop      <= wr.data[5];
					glob.pg_stop      <= wr.data[3];
					timer.fast_timers <= wr.data[2];
				end
				fm_reg_pkg::REG_LFO:     {glob.lfo_en, glob.lfo_freq} <= wr.data[3:0];
				fm_reg_pkg::REG_CLKA_HI: timer.value_a[9:2] <= wr.data;
				fm_reg_pkg::REG_CLKA_LO: timer.value_a[1:0] <= wr.data[1:0];
				fm_reg_pkg::REG_CLKB:    timer.value_b <= wr.data;
				fm_reg_pkg::REG_TIMER: begin
					glob.effect      <= |wr.data[7:6];
					timer.csm        <= wr.data[7:6] == 2'b10;
					timer.clr_flag_b <= wr.data[5];
					timer.clr_flag_a <= wr.data[4];
					timer.irq_en_b   <= wr.data[3];
					timer.irq_en_a   <= wr.data[2];
					timer.load_b     <= wr.data[1];
					timer.load_a     <= wr.data[0];
				end
				fm_reg_pkg::REG_PCM:     glob.pcm[8:1] <= wr.data;
				fm_reg_pkg::REG_DACTEST: glob.pcm[0] <= wr.data[3];
				fm_reg_pkg::REG_PCM_EN:  glob.pcm_en <= wr.data[7];
				fm_reg_pkg::REG_CLK_N6:  div_lim <= 3'd5;
				fm_reg_pkg::REG_CLK_N3:  div_lim <= 3'd2;
				fm_reg_pkg::REG_CLK_N2:  div_lim <= 3'd1;
				default: ;
			endcase
		end else if (clk_en) begin
			// flag clears are one-shot
			timer.clr_flag_a <= 1'b0;
			timer.clr_flag_b <= 1'b0;
		end
	end

	// ch3 frequencies, high part from the shared latch
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			case (wr.reg_num)
				fm_reg_pkg::REG_C3_OP1: {ch3.block_op1, ch3.fnum_op1} <= {wr.latch, wr.data};
				fm_reg_pkg::REG_C3_OP2: {ch3.block_op2, ch3.fnum_op2} <= {wr.latch, wr.data};
				fm_reg_pkg::REG_C3_OP3: {ch3.block_op3, ch3.fnum_op3} <= {wr.latch, wr.data};
				default: ;
			endcase
		end
	end

endmodule

// File: design/fm_voice_regs.sv
// ******************************
// per-channel and per-operator registers plus key-on
// field writes are read-modify-write, channel code 3 is dropped
// ******************************
`timescale 1ns/10ps

module fm_voice_regs #(
	parameter int NUM_CH = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clk_en,
	input  logic                  wr_valid,
	input  fm_reg_pkg::reg_wr_t   wr,
	output fm_voice_pkg::slot_t   cur_slot
);

	localparam int NSLOT = NUM_CH * 4;
	localparam int CH_AW = $clog2(NUM_CH);
	localparam int OP_AW = $clog2(NSLOT);

	fm_voice_pkg::ch_params_t ch_old, ch_new, ch_rd;
	fm_voice_pkg::op_params_t op_old, op_new, op_rd;
	logic [2:0]       wr_ch;   // channel of the register write
	logic [2:0]       kon_ch;  // channel of the key-on write
	logic             is_op, is_ch, is_kon;
	logic [NSLOT-1:0] keyon;   // index {ch, op code}
	logic [2:0]       cnt_ch;
	logic [1:0]       cnt_op;
	logic [4:0]       cnt_slot;

	always_comb begin
		wr_ch = {1'b0, wr.reg_num[1:0]};
		if (NUM_CH == 6 && wr.part)
			wr_ch = wr_ch + 3'd3; // part 1 -> ch 3..5
		kon_ch = {1'b0, wr.data[1:0]};
		if (NUM_CH == 6 && wr.data[2])
			kon_ch = kon_ch + 3'd3;
		is_op = wr_valid && wr.reg_num[1:0] != 2'd3 &&
			wr.reg_num >= fm_reg_pkg::REG_OP_FIRST && wr.reg_num <= fm_reg_pkg::REG_OP_LAST;
		// A0-A2 fnum low, B0-B2 fb/alg, B4-B6 rl/ams/pms
		is_ch = wr_valid && wr.reg_num[1:0] != 2'd3 &&
			wr.reg_num[7:2] inside {6'b1010_00, 6'b1011_00, 6'b1011_01};
		is_kon = wr_valid && wr.reg_num == fm_reg_pkg::REG_KON && wr.data[1:0] != 2'd3;
	end

	always_comb begin
		op_new = op_old;
		case (wr.reg_num[7:4])
			4'h3: {op_new.dt1, op_new.mul} = {wr.data[6:4], wr.data[3:0]};
			4'h4: op_new.tl = wr.data[6:0];
			4'h5: {op_new.ks, op_new.ar} = {wr.data[7:6], wr.data[4:0]};
			4'h6: {op_new.amen, op_new.d1r} = {wr.data[7], wr.data[4:0]};
			4'h7: op_new.d2r = wr.data[4:0];
			4'h8: {op_new.sl, op_new.rr} = wr.data;
			4'h9: op_new.ssg = wr.data[3:0];
			default: ;
		endcase
		ch_new = ch_old;
		case (wr.reg_num[7:2])
			6'b1010_00: {ch_new.block, ch_new.fnum} = {wr.latch, wr.data}; // latch commits here
			6'b1011_00: {ch_new.fb, ch_new.alg} = wr.data[5:0];
			6'b1011_01: {ch_new.rl, ch_new.ams, ch_new.pms} =
				{wr.data[7:6], wr.data[5:4], wr.data[2:0]};
			default: ;
		endcase
	end

	fm_param_ram #(.PAYLOAD(fm_voice_pkg::ch_params_t), .DEPTH(NUM_CH)) ch_ram (
		.clk(clk), .we(is_ch), .waddr(CH_AW'(wr_ch)), .wdata(ch_new),
		.raddr_a(CH_AW'(cnt_ch)), .rdata_a(ch_rd),
		.raddr_b(CH_AW'(wr_ch)), .rdata_b(ch_old)
	);

	fm_param_ram #(.PAYLOAD(fm_voice_pkg::op_params_t), .DEPTH(NSLOT)) op_ram (
		.clk(clk), .we(is_op), .waddr(OP_AW'({wr_ch, wr.reg_num[3:2]})), .wdata(op_new),
		.raddr_a(OP_AW'({cnt_ch, cnt_op})), .rdata_a(op_rd),
		.raddr_b(OP_AW'({wr_ch, wr.reg_num[3:2]})), .rdata_b(op_old)
	);

	always_ff @(posedge clk) begin
		if (rst)
			keyon <= '0;
		else if (is_kon)
			keyon[int'(kon_ch) * 4 +: 4] <= {wr.data[7], wr.data[5], wr.data[6], wr.data[4]}; // S4 S2 S3 S1
	end

	// operator-major walk: all channels of S1, then S3, S2, S4
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_ch   <= 3'd0;
			cnt_op   <= 2'd0;
			cnt_slot <= 5'd0;
		end else if (clk_en) begin
			if (cnt_ch == 3'(NUM_CH - 1)) begin
				cnt_ch <= 3'd0;
				cnt_op <= cnt_op + 2'd1; // wraps after S4
			end else
				cnt_ch <= cnt_ch + 3'd1;
			cnt_slot <= (cnt_slot == 5'(NSLOT - 1)) ? 5'd0 : cnt_slot + 5'd1;
		end
	end

	always_comb begin
		cur_slot       = '0; // stop bits added by the merger
		cur_slot.slot  = cnt_slot;
		cur_slot.ch    = cnt_ch;
		cur_slot.op    = cnt_op;
		cur_slot.keyon = keyon[OP_AW'({cnt_ch, cnt_op})];
		cur_slot.chp   = ch_rd;
		cur_slot.opp   = op_rd;
	end

endmodule

// File: design/fm_slot_merge.sv
// ******************************
// slot output register, loads on clk_en
// ch3 mode overrides fnum/block of channel index 2, S1..S3
// ******************************
`timescale 1ns/10ps

module fm_slot_merge (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   clk_en,
	input  fm_voice_pkg::slot_t    cur_slot,
	input  fm_reg_pkg::glob_cfg_t  glob,
	input  fm_reg_pkg::ch3_freq_t  ch3,
	output fm_voice_pkg::slot_t    slot_out
);

	fm_voice_pkg::slot_t nxt;

	always_comb begin
		nxt = cur_slot;
		if (glob.effect && cur_slot.ch == 3'd2) begin
			case (cur_slot.op)
				2'd0: {nxt.chp.block, nxt.chp.fnum} = {ch3.block_op1, ch3.fnum_op1}; // S1
				2'd1: {nxt.chp.block, nxt.chp.fnum} = {ch3.block_op3, ch3.fnum_op3}; // S3
				2'd2: {nxt.chp.block, nxt.chp.fnum} = {ch3.block_op2, ch3.fnum_op2}; // S2
				default: ; // S4 keeps the channel value
			endcase
		end
		nxt.eg_stop = glob.eg_stop;
		nxt.pg_stop = glob.pg_stop;
	end

	always_ff @(posedge clk) begin
		if (rst)
			slot_out <= '0;
		else if (clk_en)
			slot_out <= nxt; // valid 1 clk after the pulse
	end

endmodule

// File: design/fm_regs_top.sv
// ******************************
// FM register front end top
// NUM_CH 3 ignores the part bit
// ******************************
`timescale 1ns/10ps

module fm_regs_top #(
	parameter int NUM_CH     = 6,
	parameter int BUSY_CLKEN = 32
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [7:0]              din,
	input  logic                    write,
	input  logic [1:0]              addr,
	output logic                    busy,
	output logic                    clk_en,
	output fm_reg_pkg::timer_cfg_t  timer,
	output fm_reg_pkg::glob_cfg_t   glob,
	output fm_voice_pkg::slot_t     slot_out
);

	logic                  wr_valid;
	fm_reg_pkg::reg_wr_t   wr;
	fm_reg_pkg::ch3_freq_t ch3;
	fm_voice_pkg::slot_t   cur_slot;

	fm_bus_port #(.BUSY_CLKEN(BUSY_CLKEN)) u_bus (
		.clk(clk), .rst(rst), .din(din), .write(write), .addr(addr),
		.clk_en(clk_en), .wr_valid(wr_valid), .wr(wr), .busy(busy)
	);

	fm_global_regs u_glob (
		.clk(clk), .rst(rst), .wr_valid(wr_valid), .wr(wr),
		.clk_en(clk_en), .timer(timer), .glob(glob), .ch3(ch3)
	);

	fm_voice_regs #(.NUM_CH(NUM_CH)) u_voice (
		.clk(clk), .rst(rst), .clk_en(clk_en), .wr_valid(wr_valid), .wr(wr),
		.cur_slot(cur_slot)
	);

	fm_slot_merge u_merge (
		.clk(clk), .rst(rst), .clk_en(clk_en), .cur_slot(cur_slot),
		.glob(glob), .ch3(ch3), .slot_out(slot_out)
	);

endmodule

// File: sim/fm_regs_tb.sv
// ******************************
// table-driven testbench for fm_regs_top, 6 channels
// inputs change on the falling edge, filler from a 16 bit LFSR
// slot checks read slot_out after a fresh clk_en load
// ******************************
`timescale 1ns/10ps

module fm_regs_tb;

	localparam logic [3:0] K_NONE   = 4'd0;
	localparam logic [3:0] K_TMR_A  = 4'd1;
	localparam logic [3:0] K_MODE   = 4'd2; // {csm, effect}
	localparam logic [3:0] K_PCM    = 4'd3;
	localparam logic [3:0] K_DT_MUL = 4'd4; // op kinds follow register row 3..9
	localparam logic [3:0] K_TL     = 4'd5;
	localparam logic [3:0] K_KS_AR  = 4'd6;
	localparam logic [3:0] K_AM_D1R = 4'd7;
	localparam logic [3:0] K_D2R    = 4'd8;
	localparam logic [3:0] K_SL_RR  = 4'd9;
	localparam logic [3:0] K_SSG    = 4'd10;
	localparam logic [3:0] K_FREQ   = 4'd11; // {block, fnum}
	localparam logic [3:0] K_FB_ALG = 4'd12;
	localparam logic [3:0] K_PAN    = 4'd13;
	localparam logic [3:0] K_KEYON  = 4'd14;
	localparam logic [3:0] K_STOP   = 4'd15; // stop bits on slot and glob, fast_timers

	typedef struct packed {
		logic        do_wr;   // 0 = check only
		logic        part;
		logic [7:0]  reg_num;
		logic [7:0]  data;
		logic [3:0]  kind;
		logic [4:0]  slot;    // slot kinds only
		logic [15:0] expect_val;
	} entry_t;

	logic                   clk;
	logic                   rst;
	logic [7:0]             din;
	logic                   write;
	logic [1:0]             addr;
	logic                   busy;
	logic                   clk_en;
	fm_reg_pkg::timer_cfg_t timer;
	fm_reg_pkg::glob_cfg_t  glob;
	fm_voice_pkg::slot_t    slot_out;

	entry_t      tbl[$];
	logic [15:0] lfsr_state = 16'd58896;
	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;

	fm_regs_top #(.NUM_CH(6), .BUSY_CLKEN(32)) dut0 (
		.clk(clk), .rst(rst), .din(din), .write(write), .addr(addr),
		.busy(busy), .clk_en(clk_en), .timer(timer), .glob(glob), .slot_out(slot_out)
	);

	always #5 clk = ~clk;

	// x^16+x^14+x^13+x^11+1, one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		logic       fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	function automatic logic [4:0] slot_of(input int ch, input logic [1:0] op);
		return 5'(int'(op) * 6 + ch); // operator-major walk
	endfunction

	// field value a data byte should leave behind, per register layout
	function automatic logic [15:0] reg_field(input logic [3:0] kind, input logic [7:0] d);
		case (kind)
			K_DT_MUL: return 16'(d[6:0]);
			K_TL:     return 16'(d[6:0]);
			K_KS_AR:  return 16'({d[7:6], d[4:0]}); // bit 5 unused
			K_AM_D1R: return 16'({d[7], d[4:0]});
			K_D2R:    return 16'(d[4:0]);
			K_SL_RR:  return 16'(d);
			K_SSG:    return 16'(d[3:0]);
			K_FB_ALG: return 16'(d[5:0]);
			K_PAN:    return 16'({d[7:4], d[2:0]});
			default:  return 16'd0;
		endcase
	endfunction

	function automatic logic [15:0] observed(input logic [3:0] kind);
		case (kind)
			K_TMR_A:  return 16'(timer.value_a);
			K_MODE:   return 16'({timer.csm, glob.effect});
			K_PCM:    return 16'(glob.pcm);
			K_DT_MUL: return 16'({slot_out.opp.dt1, slot_out.opp.mul});
			K_TL:     return 16'(slot_out.opp.tl);
			K_KS_AR:  return 16'({slot_out.opp.ks, slot_out.opp.ar});
			K_AM_D1R: return 16'({slot_out.opp.amen, slot_out.opp.d1r});
			K_D2R:    return 16'(slot_out.opp.d2r);
			K_SL_RR:  return 16'({slot_out.opp.sl, slot_out.opp.rr});
			K_SSG:    return 16'(slot_out.opp.ssg);
			K_FREQ:   return 16'({slot_out.chp.block, slot_out.chp.fnum});
			K_FB_ALG: return 16'({slot_out.chp.fb, slot_out.chp.alg});
			K_PAN:    return 16'({slot_out.chp.rl, slot_out.chp.ams, slot_out.chp.pms});
			K_KEYON:  return 16'(slot_out.keyon);
			K_STOP:   return 16'({slot_out.eg_stop, slot_out.pg_stop, glob.eg_stop,
				glob.pg_stop, timer.fast_timers});
			default:  return 16'd0;
		endcase
	endfunction

	function automatic string kind_name(input logic [3:0] kind);
		case (kind)
			K_TMR_A:  return "timer.value_a";
			K_MODE:   return "{timer.csm,glob.effect}";
			K_PCM:    return "glob.pcm";
			K_DT_MUL: return "slot_out.{dt1,mul}";
			K_TL:     return "slot_out.tl";
			K_KS_AR:  return "slot_out.{ks,ar}";
			K_AM_D1R: return "slot_out.{amen,d1r}";
			K_D2R:    return "slot_out.d2r";
			K_SL_RR:  return "slot_out.{sl,rr}";
			K_SSG:    return "slot_out.ssg";
			K_FREQ:   return "slot_out.{block,fnum}";
			K_FB_ALG: return "slot_out.{fb,alg}";
			K_PAN:    return "slot_out.{rl,ams,pms}";
			K_KEYON:  return "slot_out.keyon";
			default:  return "{slot_out,glob}.{eg_stop,pg_stop},timer.fast_timers";
		endcase
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// one access: write high 2 clk, low 2 clk
	task automatic bus_access(input logic a0, input logic part, input logic [7:0] val);
		addr  = {part, a0};
		din   = val;
		write = 1'b1;
		repeat (2) @(negedge clk);
		write = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic write_reg(input logic part, input logic [7:0] rnum, input logic [7:0] val);
		bus_access(1'b0, part, rnum); // select
		bus_access(1'b1, part, val);  // data
	endtask

	// n = clk from call to the negedge that sees the pulse
	task automatic wait_clk_en(output int n);
		n = 0;
		forever begin
			@(negedge clk);
			n++;
			if (clk_en)
				break;
			if (n > 50) begin
				$display("clk_en did not pulse within 50 clk");
				timeouts++;
				finish_run();
			end
		end
	endtask

	task automatic wait_slot(input logic [4:0] target);
		int n;
		wait_clk_en(n); // loads after this see every earlier write
		n = 0;
		forever begin
			@(negedge clk);
			n++;
			if (slot_out.slot == target)
				break;
			if (n > 100) begin
				$display("slot %0d never showed up on slot_out", target);
				timeouts++;
				finish_run();
			end
		end
		// slot number is op * 6 + ch
		checks++;
		if (slot_out.ch !== 3'(target % 6) || slot_out.op !== 2'(target / 6)) begin
			errors++;
			$display("mismatch slot_out.{ch,op} got %h expected %h",
				{slot_out.ch, slot_out.op}, {3'(target % 6), 2'(target / 6)});
		end
	endtask

	task automatic check_period(input int period);
		int n;
		wait_clk_en(n); // first two pulses may straddle a divider change
		wait_clk_en(n);
		wait_clk_en(n);
		checks++;
		if (n != period) begin
			errors++;
			$display("mismatch clk_en period got %h expected %h", n, period);
		end
	endtask

	task automatic check_value(input logic [3:0] kind, input logic [15:0] exp);
		logic [15:0] got;
		got = observed(kind);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s got %h expected %h", kind_name(kind), got, exp);
		end
	endtask

	task automatic add_entry(input logic w, input logic p, input logic [7:0] r,
			input logic [7:0] d, input logic [3:0] k, input logic [4:0] s,
			input logic [15:0] x);
		entry_t e;
		e = '{w, p, r, d, k, s, x};
		tbl.push_back(e);
	endtask

	task automatic build_table();
		logic [7:0] d0;
		logic [7:0] d1;
		logic [5:0] lat;
		logic [1:0] op;
		logic [1:0] c;
		logic       part;
		logic [4:0] sl;
		logic [5:0] lt [4]; // 0 = channel, 1..3 = ch3 op1..op3
		logic [7:0] lo [4];
		logic [3:0] m;
		logic [3:0] by_code;
		// timers and globals
		d0 = rand_bits(8);
		d1 = rand_bits(8);
		add_entry(1, 0, 8'h24, d0, K_NONE, 0, 0);
		add_entry(1, 0, 8'h25, d1, K_TMR_A, 0, 16'({d0, d1[1:0]}));
		add_entry(1, 0, 8'h27, 8'h80, K_MODE, 0, 16'b11); // csm implies effect
		add_entry(1, 0, 8'h27, 8'h40, K_MODE, 0, 16'b01);
		add_entry(1, 0, 8'h27, 8'h00, K_MODE, 0, 16'b00);
		d0 = rand_bits(8);
		d1 = rand_bits(8);
		add_entry(1, 0, 8'h2A, d0, K_NONE, 0, 0);
		add_entry(1, 0, 8'h2C, d1, K_PCM, 0, 16'({d0, d1[3]})); // pcm lsb from dac test
		// test register, eg stop in bit 5, pg stop in bit 3, fast timers in bit 2
		add_entry(1, 0, 8'h21, 8'h24, K_STOP, 0, 16'b10101);
		add_entry(1, 0, 8'h21, 8'h08, K_STOP, 0, 16'b01010);
		add_entry(1, 0, 8'h21, 8'h00, K_STOP, 0, 16'b00000);
		// operator and channel fields, all six channels
		for (int ch = 0; ch < 6; ch++) begin
			part = ch >= 3;
			c    = 2'(ch % 3);
			op   = 2'(rand_bits(2));
			sl   = slot_of(ch, op);
			for (int g = 3; g <= 9; g++) begin
				d0 = rand_bits(8);
				add_entry(1, part, {4'(g), op, c}, d0, 4'(g + 1), sl, reg_field(4'(g + 1), d0));
			end
			lat = 6'(rand_bits(6));
			d0  = rand_bits(8);
			add_entry(1, part, 8'hA4 + {6'd0, c}, {2'b00, lat}, K_NONE, 0, 0);
			add_entry(1, part, 8'hA0 + {6'd0, c}, d0, K_FREQ, sl, 16'({lat, d0}));
			d0 = rand_bits(8);
			add_entry(1, part, 8'hB0 + {6'd0, c}, d0, K_FB_ALG, sl, reg_field(K_FB_ALG, d0));
			d0 = rand_bits(8);
			add_entry(1, part, 8'hB4 + {6'd0, c}, d0, K_PAN, sl, reg_field(K_PAN, d0));
		end
		// ch3 special mode on channel index 2
		for (int k = 0; k < 4; k++) begin
			lt[k] = 6'(rand_bits(6));
			lo[k] = rand_bits(8);
		end
		add_entry(1, 0, 8'hA6, {2'b00, lt[0]}, K_NONE, 0, 0);
		add_entry(1, 0, 8'hA2, lo[0], K_NONE, 0, 0);
		add_entry(1, 0, 8'hAD, {2'b00, lt[1]}, K_NONE, 0, 0);
		add_entry(1, 0, 8'hA9, lo[1], K_NONE, 0, 0);
		add_entry(1, 0, 8'hAE, {2'b00, lt[2]}, K_NONE, 0, 0);
		add_entry(1, 0, 8'hAA, lo[2], K_NONE, 0, 0);
		add_entry(1, 0, 8'hAC, {2'b00, lt[3]}, K_NONE, 0, 0);
		add_entry(1, 0, 8'hA8, lo[3], K_NONE, 0, 0);
		add_entry(1, 0, 8'h27, 8'h40, K_MODE, 0, 16'b01);
		add_entry(0, 0, 0, 0, K_FREQ, slot_of(2, 0), 16'({lt[1], lo[1]})); // S1
		add_entry(0, 0, 0, 0, K_FREQ, slot_of(2, 1), 16'({lt[3], lo[3]})); // S3
		add_entry(0, 0, 0, 0, K_FREQ, slot_of(2, 2), 16'({lt[2], lo[2]})); // S2
		add_entry(0, 0, 0, 0, K_FREQ, slot_of(2, 3), 16'({lt[0], lo[0]})); // S4 stays
		add_entry(1, 0, 8'h27, 8'h00, K_MODE, 0, 16'b00);
		for (int o = 0; o < 4; o++)
			add_entry(0, 0, 0, 0, K_FREQ, slot_of(2, 2'(o)), 16'({lt[0], lo[0]}));
		// key-on, part 1 code 1 is channel index 4, one operator at a time
		for (int b = 0; b < 4; b++) begin
			m = 4'b0001 << b;
			by_code = {m[3], m[1], m[2], m[0]}; // din 7..4 is S4 S3 S2 S1
			add_entry(1, 0, 8'h28, {m, 4'b0101}, K_NONE, 0, 0);
			for (int o = 0; o < 4; o++)
				add_entry(0, 0, 0, 0, K_KEYON, slot_of(4, 2'(o)), 16'(by_code[o]));
		end
		add_entry(1, 0, 8'h28, 8'hF3, K_NONE, 0, 0); // code 3, must be dropped
		for (int o = 0; o < 4; o++)
			add_entry(0, 0, 0, 0, K_KEYON, slot_of(3, 2'(o)), 16'd0);
	endtask

	task automatic run_table();
		entry_t e;
		for (int i = 0; i < tbl.size(); i++) begin
			e = tbl[i];
			if (e.do_wr)
				write_reg(e.part, e.reg_num, e.data);
			if (e.kind >= K_DT_MUL)
				wait_slot(e.slot);
			if (e.kind != K_NONE)
				check_value(e.kind, e.expect_val);
		end
	endtask

	initial begin
		int n;
		int pulses;
		clk   = 1'b0;
		rst   = 1'b1;
		din   = 8'h00;
		write = 1'b0;
		addr  = 2'b00;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		checks++;
		if (busy !== 1'b0 || clk_en !== 1'b0 || timer !== '0) begin
			errors++;
			$display("mismatch {busy,clk_en,timer} got %h expected 0", {busy, clk_en, timer});
		end
		check_period(6);
		write_reg(1'b0, 8'h2E, 8'h00);
		check_period(3);
		write_reg(1'b0, 8'h2F, 8'h00);
		check_period(2); // stays at 2 from here on
		build_table();
		run_table();
		// clear flags, high after the write, gone after next clk_en
		bus_access(1'b0, 1'b0, 8'h27);
		addr  = 2'b01;
		din   = 8'h30;
		write = 1'b1;
		repeat (2) @(negedge clk);
		checks++;
		if ({timer.clr_flag_a, timer.clr_flag_b} !== 2'b11) begin
			errors++;
			$display("mismatch timer.clr_flag got %h expected 3",
				{timer.clr_flag_a, timer.clr_flag_b});
		end
		write = 1'b0;
		wait_clk_en(n);
		@(negedge clk);
		checks++;
		if ({timer.clr_flag_a, timer.clr_flag_b} !== 2'b00) begin
			errors++;
			$display("mismatch timer.clr_flag got %h expected 0",
				{timer.clr_flag_a, timer.clr_flag_b});
		end
		// busy window, let earlier voice writes run out first
		n = 0;
		while (busy) begin
			@(negedge clk);
			n++;
			if (n > 400) begin
				$display("busy from earlier voice writes never fell");
				timeouts++;
				finish_run();
			end
		end
		write_reg(1'b0, 8'h22, 8'h0B); // lfo, below 0x30
		checks++;
		if (busy !== 1'b0) begin
			errors++;
			$display("mismatch busy got %h expected 0", busy);
		end
		checks++;
		if ({glob.lfo_en, glob.lfo_freq} !== 4'hB) begin // enable in bit 3
			errors++;
			$display("mismatch glob.{lfo_en,lfo_freq} got %h expected b",
				{glob.lfo_en, glob.lfo_freq});
		end
		bus_access(1'b0, 1'b0, 8'h30);
		addr  = 2'b01;
		din   = rand_bits(8);
		write = 1'b1;
		@(negedge clk); // accepting edge passed
		checks++;
		if (busy !== 1'b1) begin
			errors++;
			$display("mismatch busy got %h expected 1", busy);
		end
		pulses = 0;
		n = 0;
		forever begin
			if (!busy)
				break;
			if (clk_en)
				pulses++; // counted at the next posedge
			@(negedge clk);
			n++;
			if (n == 1)
				write = 1'b0;
			if (n > 400) begin
				$display("busy did not fall after the voice write");
				timeouts++;
				finish_run();
			end
		end
		checks++;
		if (pulses != 32) begin
			errors++;
			$display("mismatch busy clk_en count got %h expected %h", pulses, 32);
		end
		finish_run();
	end

endmodule

// File: build.f
design/fm_reg_pkg.sv
design/fm_voice_pkg.sv
design/fm_param_ram.sv
design/fm_bus_port.sv
design/fm_global_regs.sv
design/fm_voice_regs.sv
design/fm_slot_merge.sv
design/fm_regs_top.sv
sim/fm_regs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the FM register front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module fm_regs_tb -o fm_regs_sim \
	&& ./obj_dir/fm_regs_sim | tee /dev/stderr | grep -q "TEST PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
